/* sources.f */
common/icache_pkg.sv
icache/icache_line.sv
icache/icache_lookup.sv
icache/icache_refill.sv
icache/icache_top.sv
verif/icache_chk.sv
verif/axi_mem_model.sv
verif/tb_icache.sv

/* verif/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    import icache_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int N_TESTS         = 16;
    localparam int N_PASSES        = 2;
    localparam int WATCHDOG_CYCLES = 200 * N_TESTS * N_PASSES + 2 * RESET_CYCLES;
    // Edges counted from driving fetch_valid to seeing fetch_ready on a hit
    localparam int HIT_EDGES       = 3;

    typedef struct packed {
        logic [31:0] addr;
        logic        flush;
        logic        hit;
        logic        fault;
    } entry_t;

    // Index is addr[5:3] for the default geometry
    localparam entry_t TESTS [N_TESTS] = '{
        '{32'h0000_1000, 1'b1, 1'b0, 1'b0},
        '{32'h0000_1000, 1'b0, 1'b1, 1'b0},
        '{32'h0000_1004, 1'b0, 1'b1, 1'b0},
        '{32'h0000_1008, 1'b0, 1'b0, 1'b0},
        '{32'h0000_100C, 1'b0, 1'b1, 1'b0},
        '{32'h0000_2000, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1004, 1'b0, 1'b0, 1'b0},
        '{32'h0000_2004, 1'b0, 1'b0, 1'b0},
        '{32'h0000_100C, 1'b0, 1'b1, 1'b0},
        '{32'h0000_100C, 1'b1, 1'b0, 1'b0},
        '{32'h0000_1008, 1'b0, 1'b1, 1'b0},
        '{32'hF000_0010, 1'b0, 1'b0, 1'b1},
        '{32'hF000_0014, 1'b0, 1'b0, 1'b1},
        '{32'hF000_0010, 1'b0, 1'b0, 1'b1},
        '{32'h0000_3010, 1'b0, 1'b0, 1'b0},
        '{32'h0000_3014, 1'b0, 1'b1, 1'b0}
    };

    logic       clock;
    logic       rst_n;
    logic       fetch_valid;
    addr_t      fetch_addr;
    logic       flush;
    logic       fetch_ready;
    word_t      fetch_data;
    logic       fetch_hit;
    logic       fetch_fault;
    logic       random_delays;
    logic       arvalid;
    addr_t      araddr;
    axi_id_t    arid;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_t arburst;
    logic       rready;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    axi_resp_t  rresp;
    logic       rlast;
    axi_id_t    rid;

    icache_top #(
        .BLOCK_SIZE   (DEFAULT_BLOCK_SIZE),
        .CACHE_BLOCKS (DEFAULT_CACHE_BLOCKS)
    ) DUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .fetch_hit   (fetch_hit),
        .fetch_fault (fetch_fault),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rready      (rready),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid)
    );

    axi_mem_model #(
        .SEED       (32'h9382),
        .FAULT_BASE (32'hF000_0000)
    ) u_mem (
        .clock         (clock),
        .rst_n         (rst_n),
        .random_delays (random_delays),
        .arvalid       (arvalid),
        .araddr        (araddr),
        .arid          (arid),
        .arlen         (arlen),
        .arready       (arready),
        .rready        (rready),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rlast         (rlast),
        .rid           (rid)
    );

    bind icache_top icache_chk #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_chk (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_ready (fetch_ready),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rready      (rready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic word_t expected_word(addr_t addr, logic fault);
        if (fault) begin
            return '0;
        end
        return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic pulse_flush();
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
    endtask

    // Holds the request until fetch_ready and samples the answer on that edge
    task automatic run_fetch(input addr_t addr, output word_t data, output logic hit,
                             output logic fault, output int edges);
        edges = 0;
        @(posedge clock);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        do begin
            @(posedge clock);
            edges++;
        end while (fetch_ready !== 1'b1);
        data  = fetch_data;
        hit   = fetch_hit;
        fault = fetch_fault;
        fetch_valid <= 1'b0;
    endtask

    initial begin
        word_t data;
        logic  hit;
        logic  fault;
        int    edges;
        string tag;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        flush         = 1'b0;
        random_delays = 1'b0;
        rst_n         = 1'b1;
        @(posedge clock);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;

        // Second pass repeats the table with random AR and R delays
        for (int pass = 0; pass < N_PASSES; pass++) begin
            random_delays <= (pass != 0);
            for (int i = 0; i < N_TESTS; i++) begin
                if (TESTS[i].flush) begin
                    pulse_flush();
                end
                run_fetch(TESTS[i].addr, data, hit, fault, edges);
                tag = $sformatf("pass %0d entry %0d", pass, i);
                check_value({tag, " fetch_hit"}, 32'(hit), 32'(TESTS[i].hit));
                check_value({tag, " fetch_fault"}, 32'(fault), 32'(TESTS[i].fault));
                check_value({tag, " fetch_data"}, data,
                            expected_word(TESTS[i].addr, TESTS[i].fault));
                if (TESTS[i].hit) begin
                    check_value({tag, " hit latency"}, 32'(edges), 32'(HIT_EDGES));
                end
            end
        end

        repeat (2) @(posedge clock);
        if (DUT.u_chk.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("** Error at %0t: %0d protocol assertion failures", $time,
                     DUT.u_chk.fail_count);
            $display("Errors found");
            $fatal(1, "protocol assertions failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int unsigned SEED       = 32'h9382,
    parameter logic [31:0] FAULT_BASE = 32'hF000_0000,
    parameter int          MAX_DELAY  = 3
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  random_delays,
    input  logic                  arvalid,
    input  icache_pkg::addr_t     araddr,
    input  icache_pkg::axi_id_t   arid,
    input  icache_pkg::axi_len_t  arlen,
    output logic                  arready,
    input  logic                  rready,
    output logic                  rvalid,
    output icache_pkg::word_t     rdata,
    output icache_pkg::axi_resp_t rresp,
    output logic                  rlast,
    output icache_pkg::axi_id_t   rid
);

    import icache_pkg::*;

    localparam axi_resp_t RESP_SLVERR = 2'b10;

    logic     busy;
    addr_t    beat_addr;
    axi_len_t beats_left;
    axi_id_t  burst_id;

    function automatic int pick_delay();
        if (!random_delays) begin
            return 0;
        end
        return int'($urandom % (MAX_DELAY + 1));
    endfunction

    // Memory content is computed from the word address
    function automatic word_t mem_word(addr_t a);
        if (a >= FAULT_BASE) begin
            return '0;
        end
        return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    // Serves one burst at a time
    initial begin
        int gap;
        gap = 0;
        arready    <= 1'b0;
        rvalid     <= 1'b0;
        rdata      <= '0;
        rresp      <= AXI_RESP_OKAY;
        rlast      <= 1'b0;
        rid        <= '0;
        busy       <= 1'b0;
        beat_addr  <= '0;
        beats_left <= '0;
        burst_id   <= '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clock or negedge rst_n);
            if (!rst_n) begin
                arready    <= 1'b0;
                rvalid     <= 1'b0;
                rdata      <= '0;
                rresp      <= AXI_RESP_OKAY;
                rlast      <= 1'b0;
                rid        <= '0;
                busy       <= 1'b0;
                beat_addr  <= '0;
                beats_left <= '0;
                burst_id   <= '0;
                gap = 0;
            end else if (!busy) begin
                if (arvalid && arready) begin
                    arready    <= 1'b0;
                    busy       <= 1'b1;
                    beat_addr  <= araddr;
                    beats_left <= arlen;
                    burst_id   <= arid;
                    gap = pick_delay();
                end else if (arvalid) begin
                    if (gap == 0) begin
                        arready <= 1'b1;
                    end else begin
                        gap = gap - 1;
                    end
                end
            end else if (rvalid) begin
                if (rready) begin
                    rvalid     <= 1'b0;
                    beat_addr  <= beat_addr + 32'd4;
                    beats_left <= beats_left - 1'b1;
                    gap = pick_delay();
                    if (rlast) begin
                        busy <= 1'b0;
                    end
                end
            end else if (gap == 0) begin
                rvalid <= 1'b1;
                rdata  <= mem_word(beat_addr);
                rresp  <= (beat_addr >= FAULT_BASE) ? RESP_SLVERR : AXI_RESP_OKAY;
                rlast  <= (beats_left == 0);
                rid    <= burst_id;
            end else begin
                gap = gap - 1;
            end
        end
    end

endmodule

/* verif/icache_chk.sv */
`timescale 1ns/1ps

module icache_chk #(
    parameter int BLOCK_SIZE = icache_pkg::DEFAULT_BLOCK_SIZE
) (
    input logic                   clock,
    input logic                   rst_n,
    input logic                   fetch_ready,
    input logic                   arvalid,
    input logic                   arready,
    input icache_pkg::addr_t      araddr,
    input icache_pkg::axi_id_t    arid,
    input icache_pkg::axi_len_t   arlen,
    input icache_pkg::axi_size_t  arsize,
    input icache_pkg::axi_burst_t arburst,
    input logic                   rready
);

    import icache_pkg::*;

    int unsigned fail_count = 0;

    a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid)
            && $stable(arlen) && $stable(arsize) && $stable(arburst))
        else begin
            fail_count++;
            $error("arvalid dropped or AR fields changed before arready");
        end

    // One burst covers exactly one block
    a_ar_geometry: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid |-> (int'(arlen) + 1) * WORD_BYTES == BLOCK_SIZE
            && arburst == AXI_BURST_INCR
            && arsize == AXI_SIZE_WORD && (araddr % BLOCK_SIZE) == 0)
        else begin
            fail_count++;
            $error("AR burst does not match the block geometry");
        end

    a_ready_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_ready |=> !fetch_ready)
        else begin
            fail_count++;
            $error("fetch_ready held longer than one cycle");
        end

    a_reset_quiet: assert property (@(posedge clock)
        !rst_n |-> !fetch_ready && !arvalid && !rready)
        else begin
            fail_count++;
            $error("fetch_ready, arvalid or rready high during reset");
        end

endmodule

/* icache/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int BLOCK_SIZE   = icache_pkg::DEFAULT_BLOCK_SIZE,
    parameter int CACHE_BLOCKS = icache_pkg::DEFAULT_CACHE_BLOCKS
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   fetch_valid,
    input  icache_pkg::addr_t      fetch_addr,
    input  logic                   flush,
    output logic                   fetch_ready,
    output icache_pkg::word_t      fetch_data,
    output logic                   fetch_hit,
    output logic                   fetch_fault,
    output logic                   arvalid,
    output icache_pkg::addr_t      araddr,
    output icache_pkg::axi_id_t    arid,
    output icache_pkg::axi_len_t   arlen,
    output icache_pkg::axi_size_t  arsize,
    output icache_pkg::axi_burst_t arburst,
    output logic                   rready,
    input  logic                   arready,
    input  logic                   rvalid,
    input  icache_pkg::word_t      rdata,
    input  icache_pkg::axi_resp_t  rresp,
    input  logic                   rlast,
    input  icache_pkg::axi_id_t    rid
);

    import icache_pkg::*;

    localparam int BLOCK_WORDS = BLOCK_SIZE / WORD_BYTES;
    localparam int OFF_W       = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;
    localparam int TAG_W       = 32 - $clog2(BLOCK_SIZE) - $clog2(CACHE_BLOCKS);
    localparam int BLOCK_BITS  = BLOCK_SIZE * 8;

    logic                    req_valid;
    logic [TAG_W-1:0]        req_tag;
    logic [OFF_W-1:0]        req_offset;
    addr_t                   req_block_addr;
    logic [CACHE_BLOCKS-1:0] line_sel;
    logic                    flush_lines;
    logic                    done;
    logic [CACHE_BLOCKS-1:0] line_hit;
    logic [BLOCK_BITS-1:0]   line_block [CACHE_BLOCKS];
    logic                    fill_en;
    logic [BLOCK_BITS-1:0]   fill_block;

    icache_lookup #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .CACHE_BLOCKS  (CACHE_BLOCKS)
    ) u_lookup (
        .clock          (clock),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_addr     (fetch_addr),
        .flush          (flush),
        .done           (done),
        .req_valid      (req_valid),
        .req_tag        (req_tag),
        .req_offset     (req_offset),
        .req_block_addr (req_block_addr),
        .line_sel       (line_sel),
        .flush_lines    (flush_lines)
    );

    // Direct-mapped storage, one instance per index
    for (genvar g = 0; g < CACHE_BLOCKS; g++) begin : g_line
        icache_line #(
            .BLOCK_SIZE    (BLOCK_SIZE),
            .CACHE_BLOCKS  (CACHE_BLOCKS)
        ) u_line (
            .clock       (clock),
            .rst_n       (rst_n),
            .sel         (line_sel[g]),
            .req_tag     (req_tag),
            .flush_lines (flush_lines),
            .fill_en     (fill_en),
            .fill_block  (fill_block),
            .line_hit    (line_hit[g]),
            .line_block  (line_block[g])
        );
    end

    icache_refill #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .CACHE_BLOCKS  (CACHE_BLOCKS)
    ) u_refill (
        .clock          (clock),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_offset     (req_offset),
        .req_block_addr (req_block_addr),
        .line_hit       (line_hit),
        .line_block     (line_block),
        .done           (done),
        .fill_en        (fill_en),
        .fill_block     (fill_block),
        .fetch_ready    (fetch_ready),
        .fetch_data     (fetch_data),
        .fetch_hit      (fetch_hit),
        .fetch_fault    (fetch_fault),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arid           (arid),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rready         (rready),
        .arready        (arready),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast),
        .rid            (rid)
    );

endmodule

/* icache/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill #(
    parameter int  BLOCK_SIZE   = icache_pkg::DEFAULT_BLOCK_SIZE,
    parameter int  CACHE_BLOCKS = icache_pkg::DEFAULT_CACHE_BLOCKS,
    localparam int BLOCK_WORDS  = BLOCK_SIZE / icache_pkg::WORD_BYTES,
    localparam int OFF_W        = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1,
    localparam int BLOCK_BITS   = BLOCK_SIZE * 8
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  logic [OFF_W-1:0]        req_offset,
    input  icache_pkg::addr_t       req_block_addr,
    input  logic [CACHE_BLOCKS-1:0] line_hit,
    input  logic [BLOCK_BITS-1:0]   line_block [CACHE_BLOCKS],
    output logic                    done,
    output logic                    fill_en,
    output logic [BLOCK_BITS-1:0]   fill_block,
    output logic                    fetch_ready,
    output icache_pkg::word_t       fetch_data,
    output logic                    fetch_hit,
    output logic                    fetch_fault,
    output logic                    arvalid,
    output icache_pkg::addr_t       araddr,
    output icache_pkg::axi_id_t     arid,
    output icache_pkg::axi_len_t    arlen,
    output icache_pkg::axi_size_t   arsize,
    output icache_pkg::axi_burst_t  arburst,
    output logic                    rready,
    input  logic                    arready,
    input  logic                    rvalid,
    input  icache_pkg::word_t       rdata,
    input  icache_pkg::axi_resp_t   rresp,
    input  logic                    rlast,
    input  icache_pkg::axi_id_t     rid
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_t;

    state_t                state;
    logic [BLOCK_BITS-1:0] hit_block;
    word_t                 hit_word;
    word_t                 miss_word;
    logic [BLOCK_BITS-1:0] blk_buf;
    logic [OFF_W-1:0]      beat_cnt;
    logic                  beat_bad;
    logic                  burst_fault;
    logic                  fault_now;
    logic                  fill_pend;
    logic                  hit_start;
    logic                  last_beat;

    // At most one line hits, so an OR of the masked blocks is enough
    always_comb begin
        hit_block = '0;
        for (int i = 0; i < CACHE_BLOCKS; i++) begin
            if (line_hit[i]) begin
                hit_block = hit_block | line_block[i];
            end
        end
    end

    assign hit_word  = hit_block[req_offset*32 +: 32];
    assign hit_start = (state == S_IDLE) && req_valid && (|line_hit);
    assign last_beat = (state == S_DATA) && rvalid && rlast;

    // A stray ID counts as a bad beat too
    assign beat_bad  = (rresp != AXI_RESP_OKAY) || (rid != AXI_ID_FETCH);
    assign fault_now = burst_fault || beat_bad;

    // Last beat is still on rdata when the answer is taken
    assign miss_word = (beat_cnt == req_offset) ? rdata : blk_buf[req_offset*32 +: 32];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= (|line_hit) ? S_RESP : S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rvalid && rlast) begin
                        state <= S_RESP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Beat counter and fault record for the burst
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt    <= '0;
            burst_fault <= 1'b0;
            fill_pend   <= 1'b0;
        end else begin
            if (state == S_ADDR) begin
                beat_cnt    <= '0;
                burst_fault <= 1'b0;
            end else if (state == S_DATA && rvalid) begin
                beat_cnt    <= beat_cnt + 1'b1;
                burst_fault <= fault_now;
            end
            if (state == S_IDLE) begin
                fill_pend <= 1'b0;
            end else if (last_beat) begin
                fill_pend <= !fault_now;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_DATA && rvalid) begin
            blk_buf[beat_cnt*32 +: 32] <= rdata;
        end
        if (hit_start) begin
            fetch_data  <= hit_word;
            fetch_hit   <= 1'b1;
            fetch_fault <= 1'b0;
        end else if (last_beat) begin
            fetch_data  <= fault_now ? '0 : miss_word;
            fetch_hit   <= 1'b0;
            fetch_fault <= fault_now;
        end
    end

    // AXI read address channel
    assign arvalid = (state == S_ADDR);
    assign araddr  = req_block_addr;
    assign arid    = AXI_ID_FETCH;
    assign arlen   = axi_len_t'(BLOCK_WORDS - 1);
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_INCR;
    assign rready  = (state == S_DATA);

    assign fetch_ready = (state == S_RESP);
    assign done        = (state == S_RESP);
    assign fill_en     = (state == S_RESP) && fill_pend;
    assign fill_block  = blk_buf;

endmodule

/* icache/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup #(
    parameter int  BLOCK_SIZE   = icache_pkg::DEFAULT_BLOCK_SIZE,
    parameter int  CACHE_BLOCKS = icache_pkg::DEFAULT_CACHE_BLOCKS,
    localparam int BLOCK_WORDS  = BLOCK_SIZE / icache_pkg::WORD_BYTES,
    localparam int OFF_W        = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1,
    localparam int TAG_W        = 32 - $clog2(BLOCK_SIZE) - $clog2(CACHE_BLOCKS)
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    fetch_valid,
    input  icache_pkg::addr_t       fetch_addr,
    input  logic                    flush,
    input  logic                    done,
    output logic                    req_valid,
    output logic [TAG_W-1:0]        req_tag,
    output logic [OFF_W-1:0]        req_offset,
    output icache_pkg::addr_t       req_block_addr,
    output logic [CACHE_BLOCKS-1:0] line_sel,
    output logic                    flush_lines
);

    import icache_pkg::*;

    localparam int BYTE_OFF_W = $clog2(BLOCK_SIZE);
    localparam int INDEX_BITS = $clog2(CACHE_BLOCKS);
    localparam int IDX_W      = (INDEX_BITS > 0) ? INDEX_BITS : 1;

    logic             busy;
    logic             flush_pend;
    logic             accept;
    addr_t            req_addr;
    logic [IDX_W-1:0] req_index;

    // No new fetch while a deferred flush is outstanding
    assign accept = fetch_valid && !busy && !flush_pend;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr <= fetch_addr;
        end
    end

    // Flush during a fetch waits for done, then goes out the next cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            flush_pend <= 1'b0;
        end else if (flush && busy) begin
            flush_pend <= 1'b1;
        end else if (!busy) begin
            flush_pend <= 1'b0;
        end
    end

    assign flush_lines = !busy && (flush || flush_pend);

    // Address split
    assign req_valid      = busy;
    assign req_tag        = TAG_W'(req_addr >> (BYTE_OFF_W + INDEX_BITS));
    assign req_offset     = OFF_W'((req_addr >> $clog2(WORD_BYTES)) % BLOCK_WORDS);
    assign req_index      = IDX_W'((req_addr >> BYTE_OFF_W) % CACHE_BLOCKS);
    assign req_block_addr = req_addr & ~addr_t'(BLOCK_SIZE - 1);

    // One-hot line select
    always_comb begin
        for (int i = 0; i < CACHE_BLOCKS; i++) begin
            line_sel[i] = (req_index == IDX_W'(i));
        end
    end

endmodule

/* icache/icache_line.sv */
`timescale 1ns/1ps

module icache_line #(
    parameter int  BLOCK_SIZE   = icache_pkg::DEFAULT_BLOCK_SIZE,
    parameter int  CACHE_BLOCKS = icache_pkg::DEFAULT_CACHE_BLOCKS,
    localparam int BLOCK_BITS   = BLOCK_SIZE * 8,
    localparam int TAG_W        = 32 - $clog2(BLOCK_SIZE) - $clog2(CACHE_BLOCKS)
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  sel,
    input  logic [TAG_W-1:0]      req_tag,
    input  logic                  flush_lines,
    input  logic                  fill_en,
    input  logic [BLOCK_BITS-1:0] fill_block,
    output logic                  line_hit,
    output logic [BLOCK_BITS-1:0] line_block
);

    logic                  valid;
    logic [TAG_W-1:0]      tag;
    logic [BLOCK_BITS-1:0] data;

    // Flush wins over a fill in the same cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (flush_lines) begin
            valid <= 1'b0;
        end else if (fill_en && sel) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en && sel) begin
            tag  <= req_tag;
            data <= fill_block;
        end
    end

    // Only the selected line may report a hit
    assign line_hit   = sel && valid && (tag == req_tag);
    assign line_block = data;

endmodule

/* common/icache_pkg.sv */
package icache_pkg;

    // Fetch and bus address, instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    localparam int WORD_BYTES = 4;

    // AXI read channel field types
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;
    typedef logic [3:0] axi_id_t;

    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_size_t  AXI_SIZE_WORD  = 3'b010;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;
    localparam axi_id_t    AXI_ID_FETCH   = 4'd0;

    // Geometry used when the top level is not given other values
    localparam int DEFAULT_BLOCK_SIZE   = 8;
    localparam int DEFAULT_CACHE_BLOCKS = 8;

endpackage
